// ==== include/matrix_consts.svh ====
`ifndef MATRIX_CONSTS_SVH
`define MATRIX_CONSTS_SVH

// panel geometry
`define PIXEL_WIDTH 64   // columns
`define PIXEL_HEIGHT 32  // rows

// two bytes per pixel, 16-bit colour
`define BYTES_PER_PIXEL 2

// brightness planes
// plane 1 sits in the top bit of the enable vector
`define BRIGHTNESS_LEVELS 6

`endif

// ==== rtl/matrix_pkg.sv ====
`include "matrix_consts.svh"

package matrix_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [$clog2(`PIXEL_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`PIXEL_WIDTH)-1:0] col_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] byte_sel_t;

    // row, then inverted column, then inverted byte select
    typedef logic [$bits(row_t)+$bits(col_t)+$bits(byte_sel_t)-1:0] ram_addr_t;

    typedef logic [`BRIGHTNESS_LEVELS-1:0] bright_t;
    typedef logic [2:0] rgb_t;  // bit 0 red, 1 green, 2 blue

    typedef struct packed {
        logic      we;
        ram_addr_t addr;
        byte_t     data;
    } ram_wr_t;

    typedef enum logic [1:0] {
        cmd_idle,
        cmd_row,
        cmd_pixel,
        cmd_brightness
    } cmd_state_t;

endpackage

// ==== rtl/cmd_row_loader.sv ====
`timescale 1ns/1ns
`include "matrix_consts.svh"

module cmd_row_loader
    import matrix_pkg::*;
(
    input  logic    clk_in,
    input  logic    reset,
    input  logic    enable,
    input  byte_t   rx_data,
    input  logic    rx_valid,
    output ram_wr_t ram_wr,
    output logic    done
);
    localparam int ROW_BYTES = `PIXEL_WIDTH * `BYTES_PER_PIXEL;
    localparam int POS_W = $bits(col_t) + $bits(byte_sel_t);

    logic             have_row;
    row_t             row;
    logic [POS_W-1:0] pos;     // {column, byte select}
    logic             accept;

    // strobe arriving with done is the next command, not ours
    assign accept = enable && rx_valid && !done;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            have_row  <= 1'b0;
            pos       <= '0;
            done      <= 1'b0;
            ram_wr.we <= 1'b0;
        end else begin
            ram_wr.we <= 1'b0;
            done      <= 1'b0;
            if (accept) begin
                if (!have_row) begin
                    row      <= rx_data[$bits(row_t)-1:0];
                    have_row <= 1'b1;
                end else begin
                    ram_wr.we   <= 1'b1;
                    ram_wr.addr <= {row, ~pos};  // inverted col and byte order
                    ram_wr.data <= rx_data;
                    if (pos == POS_W'(ROW_BYTES - 1)) begin
                        pos      <= '0;
                        have_row <= 1'b0;
                        done     <= 1'b1;
                    end else begin
                        pos <= pos + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/cmd_pixel_loader.sv ====
`timescale 1ns/1ns
`include "matrix_consts.svh"

module cmd_pixel_loader
    import matrix_pkg::*;
(
    input  logic    clk_in,
    input  logic    reset,
    input  logic    enable,
    input  byte_t   rx_data,
    input  logic    rx_valid,
    output ram_wr_t ram_wr,
    output logic    done
);
    // row byte, column byte, then the pixel bytes
    localparam int STEPS = `BYTES_PER_PIXEL + 2;
    localparam int STEP_W = $clog2(STEPS);

    logic [STEP_W-1:0] step;
    row_t              row;
    col_t              col;
    byte_sel_t         sel;
    logic              accept;

    assign sel = byte_sel_t'(step - STEP_W'(2));
    assign accept = enable && rx_valid && !done;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            step      <= '0;
            done      <= 1'b0;
            ram_wr.we <= 1'b0;
        end else begin
            ram_wr.we <= 1'b0;
            done      <= 1'b0;
            if (accept) begin
                if (step == STEP_W'(0)) begin
                    row <= rx_data[$bits(row_t)-1:0];
                end else if (step == STEP_W'(1)) begin
                    col <= rx_data[$bits(col_t)-1:0];
                end else begin
                    ram_wr.we   <= 1'b1;
                    ram_wr.addr <= {row, ~col, ~sel};
                    ram_wr.data <= rx_data;
                end
                if (step == STEP_W'(STEPS - 1)) begin
                    step <= '0;
                    done <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/cmd_brightness_loader.sv ====
`timescale 1ns/1ns

module cmd_brightness_loader
    import matrix_pkg::*;
(
    input  logic    clk_in,
    input  logic    reset,
    input  logic    enable,
    input  byte_t   rx_data,
    input  logic    rx_valid,
    output bright_t value,
    output logic    load,
    output logic    done
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            load <= 1'b0;
            done <= 1'b0;
        end else begin
            load <= 1'b0;
            done <= 1'b0;
            // single byte command, so done goes out with the load
            if (enable && rx_valid && !done) begin
                value <= rx_data[$bits(bright_t)-1:0];
                load  <= 1'b1;
                done  <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/control_module.sv ====
`timescale 1ns/1ns
`include "matrix_consts.svh"

module control_module
    import matrix_pkg::*;
(
    input  logic    clk_in,
    input  logic    reset,
    input  byte_t   rx_data,
    input  logic    rx_valid,
    output rgb_t    rgb_enable,
    output bright_t brightness_enable,
    output ram_wr_t ram_wr
);
    cmd_state_t state;
    cmd_state_t next_state;
    rgb_t       next_rgb;
    bright_t    next_bright;

    ram_wr_t row_wr;
    ram_wr_t pix_wr;
    logic    row_done;
    logic    pix_done;
    logic    bri_done;
    logic    bri_load;
    bright_t bri_value;
    logic    loader_done;
    int      plane;

    assign plane = int'(rx_data) - int'("0");

    cmd_row_loader u_row (
        .clk_in   (clk_in),
        .reset    (reset),
        .enable   (state == cmd_row),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .ram_wr   (row_wr),
        .done     (row_done)
    );

    cmd_pixel_loader u_pixel (
        .clk_in   (clk_in),
        .reset    (reset),
        .enable   (state == cmd_pixel),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .ram_wr   (pix_wr),
        .done     (pix_done)
    );

    cmd_brightness_loader u_bright (
        .clk_in   (clk_in),
        .reset    (reset),
        .enable   (state == cmd_brightness),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .value    (bri_value),
        .load     (bri_load),
        .done     (bri_done)
    );

    // active loader owns the RAM write path
    always_comb begin
        ram_wr = '0;
        loader_done = 1'b0;
        case (state)
            cmd_row: begin
                ram_wr = row_wr;
                loader_done = row_done;
            end
            cmd_pixel: begin
                ram_wr = pix_wr;
                loader_done = pix_done;
            end
            cmd_brightness: loader_done = bri_done;
            default: ;
        endcase
    end

    always_comb begin
        next_state = loader_done ? cmd_idle : state;
        next_rgb = rgb_enable;
        next_bright = bri_load ? bri_value : brightness_enable;
        // a byte in the done cycle is already the next command
        if (rx_valid && (state == cmd_idle || loader_done)) begin
            case (rx_data)
                "R": next_rgb[0] = 1'b1;
                "r": next_rgb[0] = 1'b0;
                "G": next_rgb[1] = 1'b1;
                "g": next_rgb[1] = 1'b0;
                "B": next_rgb[2] = 1'b1;
                "b": next_rgb[2] = 1'b0;
                "1", "2", "3", "4", "5", "6": begin
                    // plane n is bit LEVELS-n
                    next_bright[`BRIGHTNESS_LEVELS - plane] =
                        ~next_bright[`BRIGHTNESS_LEVELS - plane];
                end
                "0": next_bright = '0;
                "9": next_bright = '1;
                "T": next_state = cmd_brightness;
                "L": next_state = cmd_row;
                "P": next_state = cmd_pixel;
                default: ;  // unknown bytes dropped
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= cmd_idle;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            state             <= next_state;
            rgb_enable        <= next_rgb;
            brightness_enable <= next_bright;
        end
    end

endmodule

// ==== rtl/frame_ram.sv ====
`timescale 1ns/1ns

module frame_ram
    import matrix_pkg::*;
(
    input  logic      clk_in,
    input  ram_wr_t   ram_wr,
    input  ram_addr_t rd_addr,
    output byte_t     rd_data
);
    localparam int DEPTH = 1 << $bits(ram_addr_t);

    byte_t mem [DEPTH];

    // write struct arrives registered, commit on this edge
    always_ff @(posedge clk_in) begin
        if (ram_wr.we) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // scanner side read port, old data on a same-address collision
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/matrix_ctrl_top.sv ====
`timescale 1ns/1ns

module matrix_ctrl_top
    import matrix_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset,
    input  byte_t     rx_data,
    input  logic      rx_valid,
    input  ram_addr_t rd_addr,
    output rgb_t      rgb_enable,
    output bright_t   brightness_enable,
    output byte_t     rd_data
);
    ram_wr_t ram_wr;

    control_module u_ctrl (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_wr            (ram_wr)
    );

    frame_ram u_ram (
        .clk_in  (clk_in),
        .ram_wr  (ram_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// ==== tb/matrix_ctrl_props.sv ====
`timescale 1ns/1ns

module matrix_ctrl_props import matrix_pkg::*; (
    input logic       clk_in,
    input logic       reset,
    input cmd_state_t state,
    input ram_wr_t    row_wr,
    input ram_wr_t    pix_wr,
    input logic       row_done,
    input logic       pix_done,
    input logic       bri_done,
    input logic       rx_valid,
    input byte_t      rx_data
);
    int   fail_count = 0;
    logic any_done;
    logic starts_loader;

    assign any_done = row_done || pix_done || bri_done;

    // a loader command in the done cycle moves straight to the next loader
    assign starts_loader = rx_valid && (rx_data inside {"T", "L", "P"});

    idle_after_reset: assert property (@(posedge clk_in) reset |=> state == cmd_idle)
        else begin
            fail_count = fail_count + 1;
            $error("state is not cmd_idle after reset");
        end

    no_write_outside_loaders: assert property (@(posedge clk_in) disable iff (reset)
        (state == cmd_idle || state == cmd_brightness) |-> !row_wr.we && !pix_wr.we)
        else begin
            fail_count = fail_count + 1;
            $error("loader write enable high in cmd_idle or cmd_brightness");
        end

    idle_after_done: assert property (@(posedge clk_in) disable iff (reset)
        any_done && !starts_loader |=> state == cmd_idle)
        else begin
            fail_count = fail_count + 1;
            $error("state did not return to cmd_idle after done");
        end

endmodule

bind control_module matrix_ctrl_props u_props (
    .clk_in   (clk_in),
    .reset    (reset),
    .state    (state),
    .row_wr   (row_wr),
    .pix_wr   (pix_wr),
    .row_done (row_done),
    .pix_done (pix_done),
    .bri_done (bri_done),
    .rx_valid (rx_valid),
    .rx_data  (rx_data)
);

// ==== tb/matrix_ctrl_checker.sv ====
`timescale 1ns/1ns

module matrix_ctrl_checker import matrix_pkg::*; (
    input  logic      clk_in,
    input  logic      reset,
    input  rgb_t      rgb_enable,
    input  bright_t   brightness_enable,
    input  ram_addr_t rd_addr,
    input  byte_t     rd_data,
    input  logic      enable_check,  // compare enables at this edge
    input  rgb_t      exp_rgb,
    input  bright_t   exp_bright,
    input  logic      read_check,    // rd_addr valid, data due next edge
    input  byte_t     exp_data,
    output int        error_count,
    output int        check_count
);
    int        errors = 0;
    int        checks = 0;
    logic      read_pending = 1'b0;
    ram_addr_t pending_addr;
    byte_t     pending_data;

    assign error_count = errors;
    assign check_count = checks;

    always @(posedge clk_in) begin
        if (enable_check && !reset) begin
            checks = checks + 1;
            if (rgb_enable !== exp_rgb || brightness_enable !== exp_bright) begin
                errors = errors + 1;
                $display("Fail at %0t: rgb_enable %b brightness_enable %b, expected %b %b",
                         $time, rgb_enable, brightness_enable, exp_rgb, exp_bright);
            end
        end
        // rd_data now holds the read issued one edge ago
        if (read_pending) begin
            checks = checks + 1;
            if (rd_data !== pending_data) begin
                errors = errors + 1;
                $display("Fail at %0t: rd_data at address %h is %h, expected %h",
                         $time, pending_addr, rd_data, pending_data);
            end
        end
        read_pending <= read_check && !reset;
        pending_addr <= rd_addr;
        pending_data <= exp_data;
    end

endmodule

// ==== tb/matrix_ctrl_tb.sv ====
`timescale 1ns/1ns
`include "matrix_consts.svh"

module matrix_ctrl_tb import matrix_pkg::*; ();
    localparam int MAX_CYCLES = 8000;  // sequence needs about 3000
    localparam int ROW_BYTES = `PIXEL_WIDTH * `BYTES_PER_PIXEL;

    logic      clk_in, reset, rx_valid, enable_check, read_check;
    byte_t     rx_data, rd_data, exp_data;
    ram_addr_t rd_addr;
    rgb_t      rgb_enable, exp_rgb;
    bright_t   brightness_enable, exp_bright;
    int        check_errors, check_total, cycle_count, test_num, errors_before;
    byte_t     exp_frame [4096];
    bit        written [4096];
    byte_t     colour_cmds [6] = '{"R", "r", "G", "g", "B", "b"};

    matrix_ctrl_top uut (.*);

    matrix_ctrl_checker u_check (.*, .error_count(check_errors), .check_count(check_total));

    // rows in order, columns and byte selects counted down within a row
    function automatic ram_addr_t byte_addr(row_t row, col_t col, byte_sel_t sel);
        int col_down;
        int sel_down;
        col_down = `PIXEL_WIDTH - 1 - int'(col);
        sel_down = `BYTES_PER_PIXEL - 1 - int'(sel);
        return ram_addr_t'(int'(row) * ROW_BYTES + col_down * `BYTES_PER_PIXEL + sel_down);
    endfunction

    function automatic rgb_t ref_rgb(byte_t c, rgb_t r);
        case (c)
            "R": r[0] = 1'b1;
            "r": r[0] = 1'b0;
            "G": r[1] = 1'b1;
            "g": r[1] = 1'b0;
            "B": r[2] = 1'b1;
            "b": r[2] = 1'b0;
            default: ;
        endcase
        return r;
    endfunction

    function automatic bright_t ref_bright(byte_t c, bright_t b);
        int n;
        n = int'(c) - int'("0");
        if (c == "0")
            b = '0;
        else if (c == "9")
            b = '1;
        else if (n >= 1 && n <= `BRIGHTNESS_LEVELS)
            b[`BRIGHTNESS_LEVELS - n] = ~b[`BRIGHTNESS_LEVELS - n];  // plane 1 is the top bit
        return b;
    endfunction

    function automatic bit is_command(byte_t c);
        return c inside {"R", "r", "G", "g", "B", "b", ["0":"6"], "9", "T", "L", "P"};
    endfunction

    function automatic int total_errors();
        return check_errors + uut.u_ctrl.u_props.fail_count;
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) @(posedge clk_in);
        #1;
    endtask

    // enters and leaves 1 ns after a clock edge
    task automatic send_byte(byte_t b, bit burst);
        if (!burst)
            repeat ($urandom_range(0, 2)) idle_cycles(1);
        rx_data = b;
        rx_valid = 1'b1;
        idle_cycles(1);
        rx_valid = 1'b0;
    endtask

    task automatic check_enables();
        enable_check = 1'b1;
        idle_cycles(1);
        enable_check = 1'b0;
    endtask

    task automatic write_model(row_t row, col_t col, byte_sel_t sel, byte_t data);
        exp_frame[byte_addr(row, col, sel)] = data;
        written[byte_addr(row, col, sel)] = 1'b1;
    endtask

    task automatic sweep_written();
        for (int a = 0; a < 4096; a++) begin
            if (written[a]) begin
                rd_addr = ram_addr_t'(a);
                exp_data = exp_frame[a];
                read_check = 1'b1;
                idle_cycles(1);
            end
        end
        read_check = 1'b0;
        idle_cycles(2);  // last compare lands one edge later
    endtask

    task automatic end_test(string name);
        test_num++;
        if (total_errors() == errors_before)
            $display("test %0d %s: ok", test_num, name);
        else
            $display("test %0d %s: %0d errors", test_num, name, total_errors() - errors_before);
        errors_before = total_errors();
    endtask

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout: test sequence still running after %0d cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        byte_t c;
        byte_t v;
        byte_t w;
        int    k;
        void'($urandom(32'h9c0e5b18));
        reset = 1'b1;
        rx_valid = 1'b0;
        rx_data = '0;
        rd_addr = '0;
        enable_check = 1'b0;
        read_check = 1'b0;
        exp_data = '0;
        exp_rgb = '1;
        exp_bright = '1;
        test_num = 0;
        errors_before = 0;
        foreach (written[i]) written[i] = 1'b0;
        repeat (8) @(posedge clk_in);
        #1 reset = 1'b0;
        idle_cycles(2);
        check_enables();
        end_test("reset values");

        repeat (20) begin
            c = colour_cmds[$urandom_range(0, 5)];
            send_byte(c, 1'b0);
            exp_rgb = ref_rgb(c, exp_rgb);
            idle_cycles(3);
            check_enables();
        end
        end_test("colour commands");

        repeat (30) begin
            k = $urandom_range(0, 8);
            if (k == 8) begin
                v = byte_t'($urandom);
                send_byte("T", 1'b0);
                send_byte(v, 1'b0);
                exp_bright = bright_t'(v);  // low 6 bits
            end else begin
                c = (k == 7) ? byte_t'("9") : byte_t'(int'("0") + k);
                send_byte(c, 1'b0);
                exp_bright = ref_bright(c, exp_bright);
            end
            idle_cycles(3);
            check_enables();
        end
        end_test("brightness");

        repeat (3) begin
            v = byte_t'($urandom);
            send_byte("L", 1'b0);
            send_byte(v, 1'b1);
            for (int i = 0; i < ROW_BYTES; i++) begin
                w = byte_t'($urandom);
                write_model(row_t'(v), col_t'(i / `BYTES_PER_PIXEL),
                            byte_sel_t'(i % `BYTES_PER_PIXEL), w);
                send_byte(w, 1'b1);
            end
            idle_cycles(3);
            sweep_written();
        end
        end_test("row load");

        repeat (8) begin
            send_byte("r", 1'b0);
            exp_rgb[0] = 1'b0;
            v = byte_t'($urandom);
            w = byte_t'($urandom);
            send_byte("P", 1'b0);
            send_byte(v, 1'b1);
            send_byte(w, 1'b1);
            for (int s = 0; s < `BYTES_PER_PIXEL; s++) begin
                c = byte_t'($urandom);
                write_model(row_t'(v), col_t'(w), byte_sel_t'(s), c);
                send_byte(c, 1'b1);
            end
            send_byte("R", 1'b1);  // lands in the done cycle
            exp_rgb[0] = 1'b1;
            idle_cycles(3);
            check_enables();
        end
        sweep_written();
        end_test("pixel load");

        repeat (10) begin
            do c = byte_t'($urandom); while (is_command(c));
            send_byte(c, 1'b0);
            idle_cycles(3);
            check_enables();
        end
        sweep_written();
        end_test("unknown bytes");

        $display("%0d tests, %0d checks, %0d errors", test_num, check_total, total_errors());
        if (total_errors() == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
rtl/matrix_pkg.sv
rtl/cmd_row_loader.sv
rtl/cmd_pixel_loader.sv
rtl/cmd_brightness_loader.sv
rtl/control_module.sv
rtl/frame_ram.sv
rtl/matrix_ctrl_top.sv
tb/matrix_ctrl_props.sv
tb/matrix_ctrl_checker.sv
tb/matrix_ctrl_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = matrix_ctrl_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
